// ==== common/adc_pkg.sv ====
package adc_pkg;

    // Sample and channel format
    localparam int SAMPLE_WIDTH = 16;
    localparam int N_CHANNELS = 4;
    localparam int CHANNEL_WIDTH = 2;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

    // Decimator sizing, accumulator holds 2^MAX_DECIMATION_LOG2 full-scale samples
    localparam int MAX_DECIMATION_LOG2 = 4;
    localparam int DECIMATION_WIDTH = 3;
    localparam int ACC_WIDTH = SAMPLE_WIDTH + MAX_DECIMATION_LOG2;

    localparam int SHIFT_WIDTH = 4;

    // Register bus
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_DATA_WIDTH = 16;

    localparam logic [REG_ADDR_WIDTH-1:0] REG_OFFSET_BASE = 5'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_SHIFT_BASE = 5'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CONTROL = 5'd8;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_DECIMATION = 5'd9;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CLEAR = 5'd10;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_FAST_THRESH_BASE = 5'd11;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_SLOW_THRESH_BASE = 5'd15;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS = 5'd19;

    // Threshold order inside one comparator group
    localparam int N_THRESHOLDS = 4;
    localparam int TH_HIGH_TRIP = 0;
    localparam int TH_HIGH_RELEASE = 1;
    localparam int TH_LOW_TRIP = 2;
    localparam int TH_LOW_RELEASE = 3;

    // Extremes of the sample range, so nothing trips out of reset
    localparam sample_t THRESH_HIGH_RESET = 16'sh7fff;
    localparam sample_t THRESH_LOW_RESET = 16'sh8000;

endpackage

// ==== hw/window_comparator.sv ====
module window_comparator (
    input  logic             clock,
    input  logic             reset,
    input  adc_pkg::sample_t sample,
    input  logic             sample_valid,
    input  adc_pkg::sample_t thresholds [adc_pkg::N_THRESHOLDS],
    input  logic             latch_mode,
    input  logic             clear_latch,
    output logic            trip_high,
    output logic            trip_low
);
    import adc_pkg::*;

    logic set_high;
    logic set_low;
    logic release_high;
    logic release_low;

    // Trip conditions only count on a valid sample
    assign set_high = sample_valid && (sample > thresholds[TH_HIGH_TRIP]);
    assign set_low = sample_valid && (sample < thresholds[TH_LOW_TRIP]);

    // Hysteresis releases on the inner threshold, latch mode only on an explicit clear
    assign release_high = latch_mode ? clear_latch :
                          (sample_valid && (sample < thresholds[TH_HIGH_RELEASE]));
    assign release_low = latch_mode ? clear_latch :
                         (sample_valid && (sample > thresholds[TH_LOW_RELEASE]));

    always_ff @(posedge clock) begin
        if (reset) begin
            trip_high <= 1'b0;
            trip_low <= 1'b0;
        end else begin
            // A new trip takes priority over a release in the same cycle
            if (set_high)
                trip_high <= 1'b1;
            else if (release_high)
                trip_high <= 1'b0;

            if (set_low)
                trip_low <= 1'b1;
            else if (release_low)
                trip_low <= 1'b0;
        end
    end

endmodule

// ==== calibration/calibration.sv ====
module calibration (
    input  logic                            clock,
    input  logic                            reset,
    input  adc_pkg::sample_t                in_data,
    input  adc_pkg::channel_t               in_channel,
    input  logic                            in_valid,
    input  adc_pkg::sample_t                offset [adc_pkg::N_CHANNELS],
    input  logic [adc_pkg::SHIFT_WIDTH-1:0] shift [adc_pkg::N_CHANNELS],
    input  logic                            shift_enable,
    output adc_pkg::sample_t                out_data,
    output adc_pkg::channel_t               out_channel,
    output logic                            out_valid
);
    import adc_pkg::*;

    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    sample_t ch_offset;
    logic [SHIFT_WIDTH-1:0] ch_shift;
    sample_t shifted;
    logic signed [SAMPLE_WIDTH:0] sum;
    sample_t saturated;

    // Coefficients of the channel being processed
    assign ch_offset = offset[in_channel];
    assign ch_shift = shift[in_channel];

    always_comb begin
        shifted = shift_enable ? (in_data >>> ch_shift) : in_data;
        // One extra bit catches overflow of the offset add
        sum = (SAMPLE_WIDTH + 1)'(shifted) + (SAMPLE_WIDTH + 1)'(ch_offset);
        if (sum[SAMPLE_WIDTH] != sum[SAMPLE_WIDTH-1])
            saturated = sum[SAMPLE_WIDTH] ? SAMPLE_MIN : SAMPLE_MAX;
        else
            saturated = sum[SAMPLE_WIDTH-1:0];
    end

    always_ff @(posedge clock) begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_data <= saturated;
            out_channel <= in_channel;
        end
    end

endmodule

// ==== decimator/averaging_decimator.sv ====
module averaging_decimator (
    input  logic                                 clock,
    input  logic                                 reset,
    input  adc_pkg::sample_t                     in_data,
    input  adc_pkg::channel_t                    in_channel,
    input  logic                                 in_valid,
    input  logic [adc_pkg::DECIMATION_WIDTH-1:0] decimation_log2,
    input  logic                                 restart,
    output adc_pkg::sample_t                     out_data,
    output adc_pkg::channel_t                    out_channel,
    output logic                                 out_valid
);
    import adc_pkg::*;

    localparam int COUNT_WIDTH = MAX_DECIMATION_LOG2 + 1;

    logic signed [ACC_WIDTH-1:0] acc [N_CHANNELS];
    logic [COUNT_WIDTH-1:0] count [N_CHANNELS];

    logic signed [ACC_WIDTH-1:0] base_acc;
    logic [COUNT_WIDTH-1:0] base_count;
    logic signed [ACC_WIDTH-1:0] next_acc;
    logic [COUNT_WIDTH-1:0] next_count;
    logic [COUNT_WIDTH-1:0] ratio;
    logic dump;
    logic signed [ACC_WIDTH-1:0] average;

    always_comb begin
        // A restart cycle treats the incoming sample as the first of a new block
        base_acc = restart ? '0 : acc[in_channel];
        base_count = restart ? '0 : count[in_channel];
        next_acc = base_acc + ACC_WIDTH'(in_data);
        next_count = base_count + 1'b1;
        ratio = COUNT_WIDTH'(1) << decimation_log2;
        dump = in_valid && (next_count >= ratio);
        // Arithmetic shift floors toward minus infinity
        average = next_acc >>> decimation_log2;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                acc[i] <= '0;
                count[i] <= '0;
            end
            out_valid <= 1'b0;
        end else begin
            if (restart) begin
                for (int i = 0; i < N_CHANNELS; i++) begin
                    acc[i] <= '0;
                    count[i] <= '0;
                end
            end
            // Per-channel accumulate, dump on the 2^k-th sample of that channel
            if (in_valid) begin
                if (dump) begin
                    acc[in_channel] <= '0;
                    count[in_channel] <= '0;
                end else begin
                    acc[in_channel] <= next_acc;
                    count[in_channel] <= next_count;
                end
            end
            out_valid <= dump;
        end
    end

    always_ff @(posedge clock) begin
        if (dump) begin
            out_data <= average[SAMPLE_WIDTH-1:0];
            out_channel <= in_channel;
        end
    end

endmodule

// ==== hw/adc_control_unit.sv ====
module adc_control_unit (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   reg_write,
    input  logic                                   reg_read,
    input  logic [adc_pkg::REG_ADDR_WIDTH-1:0]     reg_addr,
    input  logic [adc_pkg::REG_DATA_WIDTH-1:0]     reg_wdata,
    output logic [adc_pkg::REG_DATA_WIDTH-1:0]     reg_rdata,
    output adc_pkg::sample_t                       offset [adc_pkg::N_CHANNELS],
    output logic [adc_pkg::SHIFT_WIDTH-1:0]        shift [adc_pkg::N_CHANNELS],
    output logic                                   shift_enable,
    output logic [adc_pkg::DECIMATION_WIDTH-1:0]   decimation_log2,
    output logic                                   decimation_restart,
    output adc_pkg::sample_t                       fast_thresholds [adc_pkg::N_THRESHOLDS],
    output adc_pkg::sample_t                       slow_thresholds [adc_pkg::N_THRESHOLDS],
    output logic                                   fast_latch_mode,
    output logic                                   slow_latch_mode,
    output logic                                   fast_clear_latch,
    output logic                                   slow_clear_latch,
    input  logic                                   fast_trip_high,
    input  logic                                   fast_trip_low,
    input  logic                                   slow_trip_high,
    input  logic                                   slow_trip_low,
    output logic                                   fault
);
    import adc_pkg::*;

    logic [2:0] control;
    logic [DECIMATION_WIDTH-1:0] decimation_reg;
    logic [2:0] clear_pulse;
    logic fault_clear;
    logic any_trip;
    logic [REG_DATA_WIDTH-1:0] rd_value;

    assign shift_enable = control[0];
    assign fast_latch_mode = control[1];
    assign slow_latch_mode = control[2];

    // Exponents above the accumulator headroom behave as the maximum
    assign decimation_log2 = (decimation_reg > DECIMATION_WIDTH'(MAX_DECIMATION_LOG2)) ?
                             DECIMATION_WIDTH'(MAX_DECIMATION_LOG2) : decimation_reg;

    assign fast_clear_latch = clear_pulse[0];
    assign slow_clear_latch = clear_pulse[1];
    assign fault_clear = clear_pulse[2];

    assign any_trip = fast_trip_high | fast_trip_low | slow_trip_high | slow_trip_low;

    // Configuration registers
    always_ff @(posedge clock) begin
        if (reset) begin
            control <= '0;
            decimation_reg <= '0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                offset[i] <= '0;
                shift[i] <= '0;
            end
            for (int j = 0; j < N_THRESHOLDS; j += 2) begin
                fast_thresholds[j] <= (j < TH_LOW_TRIP) ? THRESH_HIGH_RESET : THRESH_LOW_RESET;
                fast_thresholds[j+1] <= (j < TH_LOW_TRIP) ? THRESH_HIGH_RESET : THRESH_LOW_RESET;
                slow_thresholds[j] <= (j < TH_LOW_TRIP) ? THRESH_HIGH_RESET : THRESH_LOW_RESET;
                slow_thresholds[j+1] <= (j < TH_LOW_TRIP) ? THRESH_HIGH_RESET : THRESH_LOW_RESET;
            end
        end else if (reg_write) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (reg_addr == REG_OFFSET_BASE + REG_ADDR_WIDTH'(i))
                    offset[i] <= sample_t'(reg_wdata);
                if (reg_addr == REG_SHIFT_BASE + REG_ADDR_WIDTH'(i))
                    shift[i] <= reg_wdata[SHIFT_WIDTH-1:0];
            end
            for (int j = 0; j < N_THRESHOLDS; j++) begin
                if (reg_addr == REG_FAST_THRESH_BASE + REG_ADDR_WIDTH'(j))
                    fast_thresholds[j] <= sample_t'(reg_wdata);
                if (reg_addr == REG_SLOW_THRESH_BASE + REG_ADDR_WIDTH'(j))
                    slow_thresholds[j] <= sample_t'(reg_wdata);
            end
            if (reg_addr == REG_CONTROL)
                control <= reg_wdata[2:0];
            if (reg_addr == REG_DECIMATION)
                decimation_reg <= reg_wdata[DECIMATION_WIDTH-1:0];
        end
    end

    // Single-cycle strobes from REG_CLEAR and REG_DECIMATION writes
    always_ff @(posedge clock) begin
        if (reset) begin
            clear_pulse <= '0;
            decimation_restart <= 1'b0;
        end else begin
            clear_pulse <= (reg_write && reg_addr == REG_CLEAR) ? reg_wdata[2:0] : 3'b000;
            decimation_restart <= reg_write && reg_addr == REG_DECIMATION;
        end
    end

    // Sticky fault, a pending trip always wins over a clear
    always_ff @(posedge clock) begin
        if (reset)
            fault <= 1'b0;
        else if (any_trip)
            fault <= 1'b1;
        else if (fault_clear)
            fault <= 1'b0;
    end

    // Readback mux, unmapped addresses read zero
    always_comb begin
        rd_value = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (reg_addr == REG_OFFSET_BASE + REG_ADDR_WIDTH'(i))
                rd_value = offset[i];
            if (reg_addr == REG_SHIFT_BASE + REG_ADDR_WIDTH'(i))
                rd_value = REG_DATA_WIDTH'(shift[i]);
        end
        for (int j = 0; j < N_THRESHOLDS; j++) begin
            if (reg_addr == REG_FAST_THRESH_BASE + REG_ADDR_WIDTH'(j))
                rd_value = fast_thresholds[j];
            if (reg_addr == REG_SLOW_THRESH_BASE + REG_ADDR_WIDTH'(j))
                rd_value = slow_thresholds[j];
        end
        if (reg_addr == REG_CONTROL)
            rd_value = REG_DATA_WIDTH'(control);
        if (reg_addr == REG_DECIMATION)
            rd_value = REG_DATA_WIDTH'(decimation_reg);
        if (reg_addr == REG_STATUS)
            rd_value = REG_DATA_WIDTH'({fault, slow_trip_low, slow_trip_high,
                                        fast_trip_low, fast_trip_high});
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clock) begin
        if (reg_read)
            reg_rdata <= rd_value;
    end

endmodule

// ==== hw/adc_processing.sv ====
module adc_processing (
    input  logic                               clock,
    input  logic                               reset,
    input  adc_pkg::sample_t                   sample_data,
    input  adc_pkg::channel_t                  sample_channel,
    input  logic                               sample_valid,
    input  logic                               reg_write,
    input  logic                               reg_read,
    input  logic [adc_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [adc_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
    output logic [adc_pkg::REG_DATA_WIDTH-1:0] reg_rdata,
    output adc_pkg::sample_t                   fast_data,
    output adc_pkg::channel_t                  fast_channel,
    output logic                               fast_valid,
    output adc_pkg::sample_t                   filtered_data,
    output adc_pkg::channel_t                  filtered_channel,
    output logic                               filtered_valid,
    output logic [1:0]                         trip_high,
    output logic [1:0]                         trip_low,
    output logic                               fault
);
    import adc_pkg::*;

    sample_t offset [N_CHANNELS];
    logic [SHIFT_WIDTH-1:0] shift [N_CHANNELS];
    logic shift_enable;
    logic [DECIMATION_WIDTH-1:0] decimation_log2;
    logic decimation_restart;
    sample_t fast_thresholds [N_THRESHOLDS];
    sample_t slow_thresholds [N_THRESHOLDS];
    logic fast_latch_mode;
    logic slow_latch_mode;
    logic fast_clear_latch;
    logic slow_clear_latch;

    adc_control_unit control_unit (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_read(reg_read),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .offset(offset),
        .shift(shift),
        .shift_enable(shift_enable),
        .decimation_log2(decimation_log2),
        .decimation_restart(decimation_restart),
        .fast_thresholds(fast_thresholds),
        .slow_thresholds(slow_thresholds),
        .fast_latch_mode(fast_latch_mode),
        .slow_latch_mode(slow_latch_mode),
        .fast_clear_latch(fast_clear_latch),
        .slow_clear_latch(slow_clear_latch),
        .fast_trip_high(trip_high[0]),
        .fast_trip_low(trip_low[0]),
        .slow_trip_high(trip_high[1]),
        .slow_trip_low(trip_low[1]),
        .fault(fault)
    );

    // Fast protection looks at the raw ADC codes
    window_comparator fast_cmp (
        .clock(clock),
        .reset(reset),
        .sample(sample_data),
        .sample_valid(sample_valid),
        .thresholds(fast_thresholds),
        .latch_mode(fast_latch_mode),
        .clear_latch(fast_clear_latch),
        .trip_high(trip_high[0]),
        .trip_low(trip_low[0])
    );

    calibration calibrator (
        .clock(clock),
        .reset(reset),
        .in_data(sample_data),
        .in_channel(sample_channel),
        .in_valid(sample_valid),
        .offset(offset),
        .shift(shift),
        .shift_enable(shift_enable),
        .out_data(fast_data),
        .out_channel(fast_channel),
        .out_valid(fast_valid)
    );

    averaging_decimator decimator (
        .clock(clock),
        .reset(reset),
        .in_data(fast_data),
        .in_channel(fast_channel),
        .in_valid(fast_valid),
        .decimation_log2(decimation_log2),
        .restart(decimation_restart),
        .out_data(filtered_data),
        .out_channel(filtered_channel),
        .out_valid(filtered_valid)
    );

    // Slow protection works on the averaged stream
    window_comparator slow_cmp (
        .clock(clock),
        .reset(reset),
        .sample(filtered_data),
        .sample_valid(filtered_valid),
        .thresholds(slow_thresholds),
        .latch_mode(slow_latch_mode),
        .clear_latch(slow_clear_latch),
        .trip_high(trip_high[1]),
        .trip_low(trip_low[1])
    );

endmodule

// ==== testbench/adc_processing_props.sv ====
module adc_processing_props (
    input logic clock,
    input logic reset,
    input logic fast_clear_latch,
    input logic slow_clear_latch,
    input logic fault_clear,
    input logic fast_trip_high,
    input logic fast_trip_low,
    input logic slow_trip_high,
    input logic slow_trip_low,
    input logic fault
);
    timeunit 1ns;
    timeprecision 1ps;

    logic trip_active;

    assign trip_active = fast_trip_high | fast_trip_low | slow_trip_high | slow_trip_low;

    assert property (@(posedge clock) disable iff (reset) fast_clear_latch |=> !fast_clear_latch)
        else $error("fast clear_latch pulse longer than one cycle");
    assert property (@(posedge clock) disable iff (reset) slow_clear_latch |=> !slow_clear_latch)
        else $error("slow clear_latch pulse longer than one cycle");
    assert property (@(posedge clock) disable iff (reset) fault_clear |=> !fault_clear)
        else $error("fault clear pulse longer than one cycle");

    // A trip forces the fault on in the next cycle, even against a clear
    assert property (@(posedge clock) disable iff (reset) trip_active |=> fault)
        else $error("fault low after an active trip");

    assert property (@(posedge clock) reset |=> !fault)
        else $error("fault high after reset");

endmodule

bind adc_control_unit adc_processing_props props (
    .clock(clock),
    .reset(reset),
    .fast_clear_latch(fast_clear_latch),
    .slow_clear_latch(slow_clear_latch),
    .fault_clear(fault_clear),
    .fast_trip_high(fast_trip_high),
    .fast_trip_low(fast_trip_low),
    .slow_trip_high(slow_trip_high),
    .slow_trip_low(slow_trip_low),
    .fault(fault)
);

// ==== testbench/adc_processing_tb.sv ====
module adc_processing_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import adc_pkg::*;

    localparam int TIMEOUT_CYCLES = 6000;

    logic clock;
    logic reset;
    sample_t sample_data;
    channel_t sample_channel;
    logic sample_valid;
    logic reg_write;
    logic reg_read;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [REG_DATA_WIDTH-1:0] reg_wdata;
    logic [REG_DATA_WIDTH-1:0] reg_rdata;
    sample_t fast_data;
    channel_t fast_channel;
    logic fast_valid;
    sample_t filtered_data;
    channel_t filtered_channel;
    logic filtered_valid;
    logic [1:0] trip_high;
    logic [1:0] trip_low;
    logic fault;

    // Register mirror and model state
    logic [15:0] mirror [0:31];
    int acc [4];
    int cnt [4];
    bit f_hi, f_lo, s_hi, s_lo, fault_m;
    int fq_data[$], fq_ch[$], sq_data[$], sq_ch[$];
    bit fq_hi[$], fq_lo[$], sq_hi[$], sq_lo[$];
    bit slow_pend, pend_hi, pend_lo, prev_any;
    int errors = 0;
    int cycles = 0;

    adc_processing uut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic int dec_k();
        int k;
        k = mirror[9][2:0];
        return (k > 4) ? 4 : k;
    endfunction

    // Shift, offset and clamp to the 16-bit signed range
    function automatic int calibrate(input int d, input int ch);
        int v;
        v = d;
        if (mirror[8][0])
            v = v >>> mirror[4+ch][3:0];
        v = v + int'($signed(mirror[ch]));
        if (v > 32767)
            v = 32767;
        if (v < -32768)
            v = -32768;
        return v;
    endfunction

    task automatic cmp_step(input int s, input int base, input bit latch,
                            inout bit hi, inout bit lo);
        if (s > int'($signed(mirror[base])))
            hi = 1'b1;
        else if (!latch && s < int'($signed(mirror[base+1])))
            hi = 1'b0;
        if (s < int'($signed(mirror[base+2])))
            lo = 1'b1;
        else if (!latch && s > int'($signed(mirror[base+3])))
            lo = 1'b0;
    endtask

    task automatic write_reg(input int addr, input int data);
        bit any_before;
        @(posedge clock);
        reg_write <= 1'b1;
        reg_addr <= 5'(addr);
        reg_wdata <= 16'(data);
        @(posedge clock);
        reg_write <= 1'b0;
        any_before = f_hi | f_lo | s_hi | s_lo;
        if (addr < 4 || (addr >= 11 && addr <= 18))
            mirror[addr] = 16'(data);
        else if (addr < 8)
            mirror[addr] = 16'(data & 15);
        else if (addr == 8)
            mirror[addr] = 16'(data & 7);
        else if (addr == 9) begin
            mirror[addr] = 16'(data & 7);
            for (int i = 0; i < 4; i++) begin
                acc[i] = 0;
                cnt[i] = 0;
            end
        end else if (addr == 10) begin
            if ((data & 1) && mirror[8][1]) begin
                f_hi = 1'b0;
                f_lo = 1'b0;
            end
            if ((data & 2) && mirror[8][2]) begin
                s_hi = 1'b0;
                s_lo = 1'b0;
            end
            if ((data & 4) && !any_before)
                fault_m = 1'b0;
        end
    endtask

    task automatic read_check(input int addr);
        int exp;
        @(posedge clock);
        reg_read <= 1'b1;
        reg_addr <= 5'(addr);
        @(posedge clock);
        reg_read <= 1'b0;
        @(negedge clock);
        if (addr == 19)
            exp = int'({fault_m, s_lo, s_hi, f_lo, f_hi});
        else
            exp = int'(mirror[addr]);
        check_value("reg_rdata", exp, int'(reg_rdata));
        // Status bits and the trip and fault ports must agree with the model
        if (addr == 19) begin
            check_value("trip_high", int'({s_hi, f_hi}), int'(trip_high));
            check_value("trip_low", int'({s_lo, f_lo}), int'(trip_low));
            check_value("fault", int'(fault_m), int'(fault));
        end
    endtask

    // Random window that trips outside and releases a little inside
    task automatic set_thresholds(input int base, input int span);
        int ht, lt;
        ht = $urandom % span;
        lt = -int'($urandom % span);
        write_reg(base, ht);
        write_reg(base + 1, ht - int'($urandom % (span / 4)));
        write_reg(base + 2, lt);
        write_reg(base + 3, lt + int'($urandom % (span / 4)));
    endtask

    task automatic send_samples(input int n);
        int d, ch, cal, avg;
        for (int i = 0; i < n; i++) begin
            d = int'($signed(16'($urandom)));
            ch = $urandom % 4;
            cmp_step(d, 11, mirror[8][1], f_hi, f_lo);
            cal = calibrate(d, ch);
            fq_data.push_back(cal);
            fq_ch.push_back(ch);
            fq_hi.push_back(f_hi);
            fq_lo.push_back(f_lo);
            acc[ch] += cal;
            cnt[ch]++;
            if (cnt[ch] == (1 << dec_k())) begin
                avg = acc[ch] >>> dec_k();
                cmp_step(avg, 15, mirror[8][2], s_hi, s_lo);
                sq_data.push_back(avg);
                sq_ch.push_back(ch);
                sq_hi.push_back(s_hi);
                sq_lo.push_back(s_lo);
                acc[ch] = 0;
                cnt[ch] = 0;
            end
            fault_m |= f_hi | f_lo | s_hi | s_lo;
            @(posedge clock);
            sample_data <= 16'(d);
            sample_channel <= 2'(ch);
            sample_valid <= 1'b1;
            if ($urandom % 2) begin
                @(posedge clock);
                sample_valid <= 1'b0;
            end
        end
        @(posedge clock);
        sample_valid <= 1'b0;
        repeat (8) @(posedge clock);
    endtask

    // Outputs are compared away from the driving edge
    always @(negedge clock) begin
        if (!reset) begin
            if (slow_pend) begin
                check_value("trip_high[1]", pend_hi, trip_high[1]);
                check_value("trip_low[1]", pend_lo, trip_low[1]);
                slow_pend = 1'b0;
            end
            if (fast_valid) begin
                if (fq_data.size() == 0) begin
                    $display("Unexpected fast_valid strobe at %0t", $time);
                    errors++;
                end else begin
                    check_value("fast_data", fq_data.pop_front(), int'(fast_data));
                    check_value("fast_channel", fq_ch.pop_front(), int'(fast_channel));
                    check_value("trip_high[0]", fq_hi.pop_front(), trip_high[0]);
                    check_value("trip_low[0]", fq_lo.pop_front(), trip_low[0]);
                end
            end
            if (filtered_valid) begin
                if (sq_data.size() == 0) begin
                    $display("Unexpected filtered_valid strobe at %0t", $time);
                    errors++;
                end else begin
                    check_value("filtered_data", sq_data.pop_front(), int'(filtered_data));
                    check_value("filtered_channel", sq_ch.pop_front(),
                                int'(filtered_channel));
                    pend_hi = sq_hi.pop_front();
                    pend_lo = sq_lo.pop_front();
                    slow_pend = 1'b1;
                end
            end
            if (prev_any && !fault) begin
                $display("Fault did not set after a trip at %0t", $time);
                errors++;
            end
            prev_any = |trip_high | |trip_low;
        end
    end

    initial begin
        void'($urandom(32'h328e1c82));
        reset = 1'b1;
        sample_data = '0;
        sample_channel = '0;
        sample_valid = 1'b0;
        reg_write = 1'b0;
        reg_read = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        for (int a = 0; a < 32; a++)
            mirror[a] = 16'h0000;
        for (int a = 11; a < 19; a++)
            mirror[a] = (a == 11 || a == 12 || a == 15 || a == 16) ? 16'h7fff : 16'h8000;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (fast_valid || filtered_valid || |trip_high || |trip_low || fault) begin
            $display("Outputs not idle after reset");
            errors++;
        end
        for (int a = 0; a < 32; a++)
            read_check(a);

        // Calibration with shift off, then on
        for (int i = 0; i < 4; i++) begin
            write_reg(i, $urandom);
            write_reg(4 + i, $urandom);
        end
        write_reg(8, 0);
        send_samples(150);
        write_reg(8, 1);
        send_samples(150);

        // Exponents 0 to 4, then an out-of-range value
        for (int k = 0; k < 6; k++) begin
            write_reg(9, (k == 5) ? 7 : k);
            send_samples(110);
        end

        // Hysteresis on both comparators
        set_thresholds(11, 30000);
        set_thresholds(15, 8000);
        write_reg(9, 1);
        send_samples(250);
        read_check(19);
        write_reg(10, 4);
        read_check(19);

        // Latch mode and clears
        write_reg(8, 7);
        send_samples(150);
        read_check(19);
        write_reg(10, 7);
        read_check(19);
        write_reg(10, 4);
        read_check(19);

        if (fq_data.size() != 0 || sq_data.size() != 0 || slow_pend) begin
            $display("Expected output strobes never arrived");
            errors++;
        end
        $display("%0d errors", errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== src.f ====
common/adc_pkg.sv
hw/window_comparator.sv
calibration/calibration.sv
decimator/averaging_decimator.sv
hw/adc_control_unit.sv
hw/adc_processing.sv
testbench/adc_processing_props.sv
testbench/adc_processing_tb.sv

// ==== Makefile ====
SHELL := /bin/bash

.PHONY: all lint clean

all:
	verilator --binary --assert --top-module adc_processing_tb -f src.f -o sim_bin --Mdir obj_dir
	set -o pipefail; ./obj_dir/sim_bin | tee sim.log
	! grep -q "FAIL: see errors above" sim.log

lint:
	verilator --lint-only --timing --assert --top-module adc_processing_tb -f src.f

clean:
	rm -rf obj_dir sim.log
